//--- hw/noc_pkg.sv
/*
  Shared definitions for the network-on-chip endpoint.
  Holds the mesh, address and flit types, the output direction encoding,
  the ingress FSM state codes and the fixed address rule table.
*/
package noc_pkg;

  // Position of a node on the 4x4 mesh
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } coord_t;

  // Wishbone word address and data
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;

  // Output port of the endpoint, seen from the local router
  typedef enum logic [2:0] {
    DirLocal,
    DirNorth,
    DirEast,
    DirSouth,
    DirWest
  } dir_e;

  // One address rule, the end address is exclusive
  typedef struct packed {
    addr_t  start_addr;
    addr_t  end_addr;
    coord_t dst;
  } id_rule_t;

  localparam int unsigned NumRules = 4;

  // Addresses from 0xE000 upwards fall through every rule and give a decode error
  localparam id_rule_t AddrMap [NumRules] = '{
    '{start_addr: 16'h0000, end_addr: 16'h4000, dst: '{x: 2'd0, y: 2'd0}},
    '{start_addr: 16'h4000, end_addr: 16'h8000, dst: '{x: 2'd2, y: 2'd1}},
    '{start_addr: 16'h8000, end_addr: 16'hC000, dst: '{x: 2'd1, y: 2'd3}},
    '{start_addr: 16'hC000, end_addr: 16'hE000, dst: '{x: 2'd3, y: 2'd3}}
  };

  // Request view of the flit payload
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } req_payload_t;

  // Response view, padded so both views have the same width
  typedef struct packed {
    logic        err;
    data_t       rdata;
    logic [15:0] pad;
  } rsp_payload_t;

  // The same payload word is read either way, is_rsp tells which one applies
  typedef union packed {
    req_payload_t req;
    rsp_payload_t rsp;
  } flit_payload_u;

  typedef struct packed {
    coord_t        dst;
    coord_t        src;
    logic          is_rsp;
    flit_payload_u payload;
  } flit_t;

  // Ingress FSM state codes
  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StWaitRsp = 2'd1;
  localparam logic [1:0] StFinish  = 2'd2;

endpackage

//--- hw/noc_wb_ingress.sv
/*
  Wishbone classic slave of the endpoint.
  Takes one request at a time, hands it to the network side and ends the
  cycle with ack or err once the response is back or the address fails.
*/
`timescale 1ns/100ps

module noc_wb_ingress import noc_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  input  logic  dec_err_i,
  input  logic  rsp_done_i,
  input  logic  rsp_err_i,
  input  data_t rsp_data_i,
  output logic  req_we_o,
  output addr_t req_addr_o,
  output data_t req_wdata_o,
  output logic  send_o
);

  logic [1:0] state_q;
  // Set while the latched request has not yet been dispatched
  logic       pending_q;

  // The route decode sees the latched address one cycle after the request is taken
  assign send_o = (state_q == StWaitRsp) && pending_q && !dec_err_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= StIdle;
      pending_q <= 1'b0;
      wb_ack_o  <= 1'b0;
      wb_err_o  <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (wb_cyc_i && wb_stb_i) begin
            state_q   <= StWaitRsp;
            pending_q <= 1'b1;
          end
        end
        StWaitRsp: begin
          if (pending_q) begin
            pending_q <= 1'b0;
            // An unmapped address is answered here and never reaches the network
            if (dec_err_i) begin
              wb_err_o <= 1'b1;
              state_q  <= StFinish;
            end
          end else if (rsp_done_i) begin
            wb_ack_o <= !rsp_err_i;
            wb_err_o <= rsp_err_i;
            state_q  <= StFinish;
          end
        end
        StFinish: begin
          // Ack or err has been up for exactly one cycle
          wb_ack_o <= 1'b0;
          wb_err_o <= 1'b0;
          state_q  <= StIdle;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Request and read data registers
  always_ff @(posedge clk_i) begin
    if ((state_q == StIdle) && wb_cyc_i && wb_stb_i) begin
      req_we_o    <= wb_we_i;
      req_addr_o  <= wb_adr_i;
      req_wdata_o <= wb_dat_i;
    end
    if ((state_q == StWaitRsp) && !pending_q && rsp_done_i) begin
      wb_dat_o <= rsp_data_i;
    end
  end

  // Ack and err are never raised together
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(wb_ack_o && wb_err_o));

endmodule

//--- hw/noc_route_comp.sv
/*
  Address decoder of the endpoint.
  Matches a word address against the rule table in the package and gives the
  destination mesh coordinates, or a decode error when no rule matches.
*/
`timescale 1ns/100ps

module noc_route_comp import noc_pkg::*; (
  input  addr_t  addr_i,
  output coord_t dst_o,
  output logic   dec_err_o
);

  // One hit bit per rule
  logic [NumRules-1:0] match;

  // All rules are compared in parallel
  always_comb begin
    for (int i = 0; i < NumRules; i++) begin
      match[i] = (addr_i >= AddrMap[i].start_addr) && (addr_i < AddrMap[i].end_addr);
    end
  end

  // Walk down so that the lowest matching rule wins
  always_comb begin
    dst_o = '0;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (match[i]) begin
        dst_o = AddrMap[i].dst;
      end
    end
  end

  // Addresses above the last rule land here
  assign dec_err_o = ~|match;

  // The table must not overlap, otherwise priority would silently pick one rule
  always_comb begin
    if (!$isunknown(addr_i)) begin
      assert final ($onehot0(match))
        else $error("Address %h matches more than one rule", addr_i);
    end
  end

endmodule

//--- hw/noc_xy_port_sel.sv
/*
  XY dimension-order port selection for the endpoint.
  Compares the destination with the endpoint's own mesh position to pick
  the output direction, and builds the request flit around the payload.
*/
`timescale 1ns/100ps

module noc_xy_port_sel import noc_pkg::*; #(
  parameter logic [1:0] OwnX = 2'd1,
  parameter logic [1:0] OwnY = 2'd1
) (
  input  coord_t dst_i,
  input  logic   we_i,
  input  addr_t  addr_i,
  input  data_t  wdata_i,
  output flit_t  flit_o,
  output dir_e   dir_o
);

  // X is resolved first, Y only once the column matches
  always_comb begin
    if (dst_i.x > OwnX) begin
      dir_o = DirEast;
    end else if (dst_i.x < OwnX) begin
      dir_o = DirWest;
    end else if (dst_i.y > OwnY) begin
      dir_o = DirNorth;
    end else if (dst_i.y < OwnY) begin
      dir_o = DirSouth;
    end else begin
      // Destination is this node itself
      dir_o = DirLocal;
    end
  end

  // Request flit with this node as source
  always_comb begin
    flit_o                     = '0;
    flit_o.dst                 = dst_i;
    flit_o.src.x               = OwnX;
    flit_o.src.y               = OwnY;
    flit_o.is_rsp              = 1'b0;
    // Payload is written through the request view of the union
    flit_o.payload.req.we      = we_i;
    flit_o.payload.req.addr    = addr_i;
    flit_o.payload.req.wdata   = wdata_i;
  end

endmodule

//--- hw/noc_egress.sv
/*
  Network side of the endpoint.
  Registers the request flit and holds it until the link takes it, then
  opens the response port and decodes the response view of the payload.
*/
`timescale 1ns/100ps

module noc_egress import noc_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  send_i,
  input  flit_t req_flit_i,
  input  dir_e  req_dir_i,
  output logic  flit_valid_o,
  input  logic  flit_ready_i,
  output flit_t flit_o,
  output dir_e  flit_dir_o,
  input  logic  rsp_valid_i,
  output logic  rsp_ready_o,
  input  flit_t rsp_flit_i,
  output logic  rsp_done_o,
  output logic  rsp_err_o,
  output data_t rsp_data_o
);

  // A response is taken in the cycle where both sides agree
  assign rsp_done_o = rsp_valid_i && rsp_ready_o;

  // Response fields come straight from the response view
  assign rsp_err_o  = rsp_flit_i.payload.rsp.err;
  assign rsp_data_o = rsp_flit_i.payload.rsp.rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flit_valid_o <= 1'b0;
      rsp_ready_o  <= 1'b0;
    end else begin
      if (send_i) begin
        flit_valid_o <= 1'b1;
      end else if (flit_valid_o && flit_ready_i) begin
        // Request is gone, now wait for its answer
        flit_valid_o <= 1'b0;
        rsp_ready_o  <= 1'b1;
      end
      if (rsp_done_o) begin
        rsp_ready_o <= 1'b0;
      end
    end
  end

  // Outgoing flit register, only loaded on a new request
  always_ff @(posedge clk_i) begin
    if (send_i) begin
      flit_o     <= req_flit_i;
      flit_dir_o <= req_dir_i;
    end
  end

  // Under back-pressure the offered flit must not change or go away
  assert property (@(posedge clk_i) disable iff (reset_i)
    flit_valid_o && !flit_ready_i |=>
      flit_valid_o && $stable(flit_o) && $stable(flit_dir_o));

  // Only a response flit may be accepted on the return port
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i && rsp_ready_o |-> rsp_flit_i.is_rsp);

endmodule

//--- hw/noc_endpoint_top.sv
/*
  Top level of the network-on-chip endpoint.
  Connects the Wishbone ingress, the address decoder, the XY port selection
  and the flit egress. OwnX and OwnY place the endpoint on the mesh.
*/
`timescale 1ns/100ps

module noc_endpoint_top import noc_pkg::*; #(
  parameter logic [1:0] OwnX = 2'd1,
  parameter logic [1:0] OwnY = 2'd1
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  output logic  flit_valid_o,
  input  logic  flit_ready_i,
  output flit_t flit_o,
  output dir_e  flit_dir_o,
  input  logic  rsp_valid_i,
  output logic  rsp_ready_o,
  input  flit_t rsp_flit_i
);

  // Latched request
  logic   req_we;
  addr_t  req_addr;
  data_t  req_wdata;
  logic   send;
  // Decode and routing results
  coord_t dst;
  logic   dec_err;
  flit_t  req_flit;
  dir_e   req_dir;
  // Response handed back to the ingress
  logic   rsp_done;
  logic   rsp_err;
  data_t  rsp_data;

  noc_wb_ingress i_ingress (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .dec_err_i   (dec_err),
    .rsp_done_i  (rsp_done),
    .rsp_err_i   (rsp_err),
    .rsp_data_i  (rsp_data),
    .req_we_o    (req_we),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .send_o      (send)
  );

  noc_route_comp i_route_comp (
    .addr_i    (req_addr),
    .dst_o     (dst),
    .dec_err_o (dec_err)
  );

  noc_xy_port_sel #(
    .OwnX (OwnX),
    .OwnY (OwnY)
  ) i_port_sel (
    .dst_i   (dst),
    .we_i    (req_we),
    .addr_i  (req_addr),
    .wdata_i (req_wdata),
    .flit_o  (req_flit),
    .dir_o   (req_dir)
  );

  noc_egress i_egress (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .send_i       (send),
    .req_flit_i   (req_flit),
    .req_dir_i    (req_dir),
    .flit_valid_o (flit_valid_o),
    .flit_ready_i (flit_ready_i),
    .flit_o       (flit_o),
    .flit_dir_o   (flit_dir_o),
    .rsp_valid_i  (rsp_valid_i),
    .rsp_ready_o  (rsp_ready_o),
    .rsp_flit_i   (rsp_flit_i),
    .rsp_done_o   (rsp_done),
    .rsp_err_o    (rsp_err),
    .rsp_data_o   (rsp_data)
  );

endmodule

//--- sim/tb_noc_endpoint.sv
/*
  Self-checking testbench for the network-on-chip endpoint.
  Acts as the Wishbone master and as the network. Each line of the vectors
  file is one transaction, checked from request flit to ack or err.
*/
`timescale 1ns/100ps

module tb_noc_endpoint
  import noc_pkg::*;
();

  // Mesh position of the DUT
  localparam logic [1:0] OwnX = 2'd1;
  localparam logic [1:0] OwnY = 2'd1;
  localparam int MaxVec = 64;
  localparam int Timeout = 50;

  logic  clk_i;
  logic  reset_i;
  logic  wb_cyc_i;
  logic  wb_stb_i;
  logic  wb_we_i;
  addr_t wb_adr_i;
  data_t wb_dat_i;
  data_t wb_dat_o;
  logic  wb_ack_o;
  logic  wb_err_o;
  logic  flit_valid_o;
  logic  flit_ready_i;
  flit_t flit_o;
  dir_e  flit_dir_o;
  logic  rsp_valid_i;
  logic  rsp_ready_o;
  flit_t rsp_flit_i;

  // Five words per transaction as we, addr, wdata, rdata and err
  logic [31:0] vec_mem [MaxVec*5];
  logic [31:0] lfsr_q;
  int          errors;
  int          num_vec;
  bit          timed_out;

  noc_endpoint_top #(
    .OwnX (OwnX),
    .OwnY (OwnY)
  ) uut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .flit_valid_o (flit_valid_o),
    .flit_ready_i (flit_ready_i),
    .flit_o       (flit_o),
    .flit_dir_o   (flit_dir_o),
    .rsp_valid_i  (rsp_valid_i),
    .rsp_ready_o  (rsp_ready_o),
    .rsp_flit_i   (rsp_flit_i)
  );

  always #10 clk_i = ~clk_i;

  // Inputs change and outputs are looked at 2 ns after each rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step for every bit drawn
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = (val << 1) | lfsr_q[0];
    end
  endtask

  // Address map as {unmapped, x, y}
  function automatic logic [4:0] expect_route(input logic [15:0] a);
    if (a < 16'h4000) return {1'b0, 2'd0, 2'd0};
    if (a < 16'h8000) return {1'b0, 2'd2, 2'd1};
    if (a < 16'hC000) return {1'b0, 2'd1, 2'd3};
    if (a < 16'hE000) return {1'b0, 2'd3, 2'd3};
    return 5'b1_0000;
  endfunction

  // Column first, then row
  function automatic dir_e expect_dir(input logic [1:0] x, input logic [1:0] y);
    if (x > OwnX) return DirEast;
    if (x < OwnX) return DirWest;
    if (y > OwnY) return DirNorth;
    if (y < OwnY) return DirSouth;
    return DirLocal;
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0d ns while waiting for %s", $time, what);
    errors++;
    timed_out = 1'b1;
  endtask

  // Drops the cycle and makes sure ack or err was a single pulse
  task automatic end_cycle();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    next_cycle();
    if (wb_ack_o || wb_err_o) report_fail("termination lasted more than one cycle");
  endtask

  task automatic run_vector(input int idx);
    logic        we;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rerr;
    logic [4:0]  route;
    flit_t       held;
    int          cnt;
    int          hold;
    we    = vec_mem[idx*5][0];
    addr  = vec_mem[idx*5+1][15:0];
    wdata = vec_mem[idx*5+2];
    rdata = vec_mem[idx*5+3];
    rerr  = vec_mem[idx*5+4][0];
    route = expect_route(addr);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    cnt = 0;
    while (!flit_valid_o && !wb_err_o && !wb_ack_o && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (cnt == Timeout) begin
      report_timeout("a request flit or an early termination");
      return;
    end
    // Unmapped addresses end right away and never reach the link
    if (route[4]) begin
      if (flit_valid_o) report_fail($sformatf("flit sent for unmapped address %h", addr));
      if (!wb_err_o) report_fail($sformatf("no err for unmapped address %h", addr));
      end_cycle();
      return;
    end
    if (!flit_valid_o) begin
      report_fail($sformatf("cycle to %h ended without a flit", addr));
      end_cycle();
      return;
    end
    if (flit_o.dst !== route[3:0] || flit_dir_o !== expect_dir(route[3:2], route[1:0]))
      report_fail($sformatf("addr %h dst %h dir %0d, expected %h dir %0d", addr, flit_o.dst,
                            flit_dir_o, route[3:0], expect_dir(route[3:2], route[1:0])));
    if (flit_o.payload.req.we !== we || flit_o.payload.req.addr !== addr ||
        flit_o.payload.req.wdata !== wdata)
      report_fail($sformatf("payload we %b addr %h wdata %h, expected %b %h %h",
                            flit_o.payload.req.we, flit_o.payload.req.addr,
                            flit_o.payload.req.wdata, we, addr, wdata));
    if (flit_o.is_rsp !== 1'b0 || flit_o.src !== {OwnX, OwnY})
      report_fail($sformatf("header is_rsp %b src %h", flit_o.is_rsp, flit_o.src));
    // The offer must not move during 0 to 3 cycles of back-pressure
    held = flit_o;
    draw_bits(2, hold);
    repeat (hold) begin
      next_cycle();
      if (!flit_valid_o || flit_o !== held) report_fail("flit changed under back-pressure");
    end
    flit_ready_i = 1'b1;
    next_cycle();
    flit_ready_i = 1'b0;
    if (flit_valid_o) report_fail("flit still valid after the handshake");
    // Network latency before the answer comes back
    draw_bits(2, hold);
    repeat (hold) next_cycle();
    rsp_flit_i = '0;
    rsp_flit_i.dst.x = OwnX;
    rsp_flit_i.dst.y = OwnY;
    rsp_flit_i.src = route[3:0];
    rsp_flit_i.is_rsp = 1'b1;
    rsp_flit_i.payload.rsp.err = rerr;
    rsp_flit_i.payload.rsp.rdata = rdata;
    rsp_valid_i = 1'b1;
    cnt = 0;
    while (!rsp_ready_o && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (cnt == Timeout) begin
      report_timeout("the response port to open");
      return;
    end
    next_cycle();
    rsp_valid_i = 1'b0;
    if (rsp_ready_o) report_fail("response port still open after the response");
    cnt = 0;
    while (!wb_ack_o && !wb_err_o && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (cnt == Timeout) begin
      report_timeout("ack or err after the response");
      return;
    end
    if (wb_ack_o !== !rerr || wb_err_o !== rerr)
      report_fail($sformatf("addr %h ack %b err %b, response err %b", addr, wb_ack_o,
                            wb_err_o, rerr));
    if (!we && !rerr && wb_dat_o !== rdata)
      report_fail($sformatf("read %h gave %h, expected %h", addr, wb_dat_o, rdata));
    end_cycle();
  endtask

  initial begin
    int idx;
    errors       = 0;
    num_vec      = 0;
    timed_out    = 1'b0;
    lfsr_q       = 32'h7a69_6e87;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    flit_ready_i = 1'b0;
    rsp_valid_i  = 1'b0;
    rsp_flit_i   = '0;
    $readmemh("sim/noc_endpoint_vectors.txt", vec_mem);
    // Words left unknown mark the end of the file
    while (num_vec < MaxVec && !$isunknown(vec_mem[num_vec*5+1])) num_vec++;
    if (num_vec == 0) begin
      $display("No transactions could be read from the vectors file");
      errors++;
    end
    repeat (4) next_cycle();
    reset_i = 1'b0;
    if (wb_ack_o || wb_err_o || flit_valid_o || rsp_ready_o)
      report_fail("handshake outputs not low after reset");
    for (idx = 0; idx < num_vec && !timed_out; idx++) begin
      run_vector(idx);
    end
    $display("Transactions %0d, errors %0d", num_vec, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sim/noc_endpoint_vectors.txt
// Columns: we addr wdata rdata err, all hex, one transaction per line
// rdata and err are the network's answer, unmapped addresses never get one
0 0000 00000000 11110000 0
1 0004 cafe0001 00000000 0
0 3ffc 00000000 2222beef 0
0 3fff 00000000 0f0f0f0f 0
0 4000 00000000 33334000 0
1 4abc 12345678 00000000 0
0 7fff 00000000 7fff7fff 0
1 7ff0 deadbeef 00000000 1
0 8000 00000000 44448000 0
1 9a00 a5a5a5a5 00000000 0
0 bfff 00000000 bfffbfff 0
0 a000 00000000 00000000 1
0 c000 00000000 5555c000 0
1 c124 0badf00d 00000000 0
0 dfff 00000000 dfffdfff 0
1 d000 87654321 00000000 1
0 e000 00000000 00000000 0
1 e000 ffffffff 00000000 0
0 f123 00000000 00000000 0
0 ffff 00000000 00000000 0
1 fffe 13572468 00000000 0
0 1234 00000000 ffffffff 0
1 5678 00000001 00000000 0
0 89ab 00000000 80000000 0
0 cdef 00000000 00000000 0

//--- noc_endpoint_top.f
hw/noc_pkg.sv
hw/noc_wb_ingress.sv
hw/noc_route_comp.sv
hw/noc_xy_port_sel.sv
hw/noc_egress.sv
hw/noc_endpoint_top.sv
sim/tb_noc_endpoint.sv

//--- Bender.yml
package:
  name: noc_endpoint

sources:
  - hw/noc_pkg.sv
  - hw/noc_wb_ingress.sv
  - hw/noc_route_comp.sv
  - hw/noc_xy_port_sel.sv
  - hw/noc_egress.sv
  - hw/noc_endpoint_top.sv
  - target: simulation
    files:
      - sim/tb_noc_endpoint.sv
